/* filelist.f */
+incdir+testbench
logic/rv_isa_pkg.sv
logic/core_ctrl_pkg.sv
logic/reg_file.sv
logic/instr_decoder.sv
logic/alu.sv
logic/lsu.sv
logic/fetch_unit.sv
logic/rv_core.sv
testbench/tb_rv_core.sv

/* logic/alu.sv */
`timescale 1ns/1ns

module alu (
    input  rv_isa_pkg::xlen_t       a,
    input  rv_isa_pkg::xlen_t       b,
    input  core_ctrl_pkg::alu_op_e  op,
    input  logic                    word_op,
    output rv_isa_pkg::xlen_t       result,
    output logic                    equal
);

    rv_isa_pkg::xlen_t raw;
    rv_isa_pkg::word_t low;

    always_comb begin
        case (op)
            core_ctrl_pkg::alu_add: begin
                raw = a + b;
            end
            core_ctrl_pkg::alu_sub: begin
                raw = a - b;
            end
            default: begin
                raw = b;  // lui immediate
            end
        endcase
    end

    assign low = raw[31:0];

    // W forms keep only the low word, sign-extended
    assign result = word_op ? {{32{low[31]}}, low} : raw;

    assign equal = (a == b);  // for beq/bne, independent of op

endmodule

/* logic/core_ctrl_pkg.sv */
package core_ctrl_pkg;

    typedef enum logic [1:0] {
        alu_add,
        alu_sub,
        alu_pass_b   // lui
    } alu_op_e;

    typedef enum logic [1:0] {
        wb_alu,
        wb_load,
        wb_pc_plus4  // link value for jal/jalr
    } wb_sel_e;

    typedef enum logic [1:0] {
        size_b,
        size_w,
        size_d
    } mem_size_e;

    typedef struct packed {
        rv_isa_pkg::reg_addr_t rd;
        rv_isa_pkg::reg_addr_t rs1;
        rv_isa_pkg::reg_addr_t rs2;
        rv_isa_pkg::xlen_t     imm;        // already sign-extended
        alu_op_e               alu_op;
        logic                  use_imm;    // alu b from imm instead of rs2
        logic                  word_op;    // sign-extend bits 31:0
        logic                  reg_wen;
        wb_sel_e               wb_sel;
        logic                  mem_read;
        logic                  mem_write;
        mem_size_e             mem_size;
        logic                  is_branch;
        logic                  branch_ne;  // bne, taken when not equal
        logic                  is_jal;
        logic                  is_jalr;
    } ctrl_t;

    typedef struct packed {
        rv_isa_pkg::xlen_t      addr;   // 8-byte aligned
        rv_isa_pkg::xlen_t      wdata;  // shifted into the addressed lane
        rv_isa_pkg::byte_mask_t wmask;
        logic                   wen;
        logic                   ren;
    } dmem_req_t;

endpackage

/* logic/fetch_unit.sv */
`timescale 1ns/1ns

module fetch_unit #(
    parameter rv_isa_pkg::xlen_t reset_pc = 64'h0000_0000_8000_0000
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  core_ctrl_pkg::ctrl_t  ctrl,
    input  rv_isa_pkg::xlen_t     rs1_value,
    input  logic                  equal,
    output rv_isa_pkg::xlen_t     pc,
    output rv_isa_pkg::xlen_t     pc_plus4
);

    rv_isa_pkg::xlen_t pc_next;
    rv_isa_pkg::xlen_t rel_target;
    rv_isa_pkg::xlen_t jalr_target;
    logic              branch_taken;

    assign pc_plus4     = pc + 64'd4;
    assign rel_target   = pc + ctrl.imm;  // branch and jal
    assign jalr_target  = (rs1_value + ctrl.imm) & ~64'd1;
    assign branch_taken = ctrl.is_branch && (equal ^ ctrl.branch_ne);

    always_comb begin
        if (ctrl.is_jalr) begin
            pc_next = jalr_target;
        end else if (ctrl.is_jal || branch_taken) begin
            pc_next = rel_target;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= reset_pc;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

/* logic/instr_decoder.sv */
`timescale 1ns/1ns

module instr_decoder (
    input  rv_isa_pkg::instr_t    instr,
    output core_ctrl_pkg::ctrl_t  ctrl
);

    rv_isa_pkg::instr_fields_t f;
    rv_isa_pkg::xlen_t imm_i;
    rv_isa_pkg::xlen_t imm_s;
    rv_isa_pkg::xlen_t imm_b;
    rv_isa_pkg::xlen_t imm_u;
    rv_isa_pkg::xlen_t imm_j;

    assign f = rv_isa_pkg::instr_fields_t'(instr);

    assign imm_i = {{52{instr[31]}}, instr[31:20]};
    assign imm_s = {{52{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{51{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};
    assign imm_j = {{43{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        ctrl          = '0;  // anything not matched below is a no-op
        ctrl.rd       = f.rd;
        ctrl.rs1      = f.rs1;
        ctrl.rs2      = f.rs2;
        ctrl.alu_op   = core_ctrl_pkg::alu_add;
        ctrl.wb_sel   = core_ctrl_pkg::wb_alu;
        ctrl.mem_size = core_ctrl_pkg::size_d;

        case (f.opcode)
            rv_isa_pkg::op_lui: begin
                ctrl.imm     = imm_u;
                ctrl.alu_op  = core_ctrl_pkg::alu_pass_b;
                ctrl.use_imm = 1'b1;
                ctrl.reg_wen = 1'b1;
            end
            rv_isa_pkg::op_op_imm, rv_isa_pkg::op_op_imm_32: begin
                if (f.funct3 == rv_isa_pkg::f3_add) begin  // addi / addiw
                    ctrl.imm     = imm_i;
                    ctrl.use_imm = 1'b1;
                    ctrl.word_op = (f.opcode == rv_isa_pkg::op_op_imm_32);
                    ctrl.reg_wen = 1'b1;
                end
            end
            rv_isa_pkg::op_op: begin
                if (f.funct3 == rv_isa_pkg::f3_add) begin
                    if (f.funct7 == rv_isa_pkg::f7_base) begin
                        ctrl.reg_wen = 1'b1;
                    end else if (f.funct7 == rv_isa_pkg::f7_sub) begin
                        ctrl.alu_op  = core_ctrl_pkg::alu_sub;
                        ctrl.reg_wen = 1'b1;
                    end
                end
            end
            rv_isa_pkg::op_op_32: begin
                if (f.funct3 == rv_isa_pkg::f3_add && f.funct7 == rv_isa_pkg::f7_base) begin
                    ctrl.word_op = 1'b1;  // addw only
                    ctrl.reg_wen = 1'b1;
                end
            end
            rv_isa_pkg::op_load: begin
                if (f.funct3 == rv_isa_pkg::f3_word || f.funct3 == rv_isa_pkg::f3_double) begin
                    ctrl.imm      = imm_i;
                    ctrl.use_imm  = 1'b1;
                    ctrl.mem_read = 1'b1;
                    ctrl.reg_wen  = 1'b1;
                    ctrl.wb_sel   = core_ctrl_pkg::wb_load;
                    ctrl.mem_size = (f.funct3 == rv_isa_pkg::f3_word) ?
                                    core_ctrl_pkg::size_w : core_ctrl_pkg::size_d;
                end
            end
            rv_isa_pkg::op_store: begin
                ctrl.imm     = imm_s;
                ctrl.use_imm = 1'b1;
                case (f.funct3)
                    rv_isa_pkg::f3_byte: begin
                        ctrl.mem_write = 1'b1;
                        ctrl.mem_size  = core_ctrl_pkg::size_b;
                    end
                    rv_isa_pkg::f3_word: begin
                        ctrl.mem_write = 1'b1;
                        ctrl.mem_size  = core_ctrl_pkg::size_w;
                    end
                    rv_isa_pkg::f3_double: begin
                        ctrl.mem_write = 1'b1;
                    end
                    default: ;  // sh and others dropped
                endcase
            end
            rv_isa_pkg::op_branch: begin
                if (f.funct3 == rv_isa_pkg::f3_beq || f.funct3 == rv_isa_pkg::f3_bne) begin
                    ctrl.imm       = imm_b;
                    ctrl.is_branch = 1'b1;
                    ctrl.branch_ne = (f.funct3 == rv_isa_pkg::f3_bne);
                end
            end
            rv_isa_pkg::op_jal: begin
                ctrl.imm     = imm_j;
                ctrl.is_jal  = 1'b1;
                ctrl.reg_wen = 1'b1;
                ctrl.wb_sel  = core_ctrl_pkg::wb_pc_plus4;
            end
            rv_isa_pkg::op_jalr: begin
                if (f.funct3 == rv_isa_pkg::f3_jalr) begin
                    ctrl.imm     = imm_i;
                    ctrl.use_imm = 1'b1;
                    ctrl.is_jalr = 1'b1;
                    ctrl.reg_wen = 1'b1;
                    ctrl.wb_sel  = core_ctrl_pkg::wb_pc_plus4;
                end
            end
            default: ;
        endcase
    end

endmodule

/* logic/lsu.sv */
`timescale 1ns/1ns

module lsu (
    input  core_ctrl_pkg::ctrl_t      ctrl,
    input  rv_isa_pkg::xlen_t         addr,
    input  rv_isa_pkg::xlen_t         store_data,
    input  rv_isa_pkg::xlen_t         dmem_rdata,
    output core_ctrl_pkg::dmem_req_t  dmem_req,
    output rv_isa_pkg::xlen_t         load_data
);

    logic [2:0]             lane;
    rv_isa_pkg::byte_mask_t mask;
    rv_isa_pkg::xlen_t      wdata;
    rv_isa_pkg::word_t      load_word;

    assign lane = addr[2:0];

    always_comb begin
        case (ctrl.mem_size)
            core_ctrl_pkg::size_b: begin
                mask  = rv_isa_pkg::byte_mask_t'(8'h01) << lane;
                wdata = store_data << {lane, 3'b000};
            end
            core_ctrl_pkg::size_w: begin
                mask  = rv_isa_pkg::byte_mask_t'(8'h0f) << {lane[2], 2'b00};
                wdata = store_data << {lane[2], 5'b00000};  // upper or lower word
            end
            default: begin
                mask  = 8'hff;
                wdata = store_data;
            end
        endcase
    end

    assign dmem_req.addr  = {addr[63:3], 3'b000};
    assign dmem_req.wdata = wdata;
    assign dmem_req.wmask = mask;
    assign dmem_req.wen   = ctrl.mem_write;
    assign dmem_req.ren   = ctrl.mem_read;

    assign load_word = lane[2] ? dmem_rdata[63:32] : dmem_rdata[31:0];

    always_comb begin
        if (ctrl.mem_size == core_ctrl_pkg::size_w) begin
            load_data = {{32{load_word[31]}}, load_word};  // lw
        end else begin
            load_data = dmem_rdata;  // ld
        end
    end

endmodule

/* logic/reg_file.sv */
`timescale 1ns/1ns

module reg_file (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wen,
    input  rv_isa_pkg::reg_addr_t waddr,
    input  rv_isa_pkg::xlen_t     wdata,
    input  rv_isa_pkg::reg_addr_t raddr1,
    input  rv_isa_pkg::reg_addr_t raddr2,
    output rv_isa_pkg::xlen_t     rdata1,
    output rv_isa_pkg::xlen_t     rdata2
);

    rv_isa_pkg::xlen_t regs [1:31];  // x0 has no storage

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (waddr != '0)) begin  // writes to x0 dropped
            regs[waddr] <= wdata;
        end
    end

    // reads see the value before this cycle's write
    always_comb begin
        if (raddr1 == '0) begin
            rdata1 = '0;
        end else begin
            rdata1 = regs[raddr1];
        end
    end

    always_comb begin
        if (raddr2 == '0) begin
            rdata2 = '0;
        end else begin
            rdata2 = regs[raddr2];
        end
    end

endmodule

/* logic/rv_core.sv */
`timescale 1ns/1ns

module rv_core #(
    parameter rv_isa_pkg::xlen_t reset_pc = 64'h0000_0000_8000_0000
) (
    input  logic                      clk,
    input  logic                      rst_n,
    output rv_isa_pkg::xlen_t         imem_addr,
    input  rv_isa_pkg::instr_t        imem_rdata,
    output core_ctrl_pkg::dmem_req_t  dmem_req,
    input  rv_isa_pkg::xlen_t         dmem_rdata
);

    core_ctrl_pkg::ctrl_t ctrl;
    core_ctrl_pkg::ctrl_t ctrl_mem;
    rv_isa_pkg::xlen_t    pc;
    rv_isa_pkg::xlen_t    pc_plus4;
    rv_isa_pkg::xlen_t    rs1_value;
    rv_isa_pkg::xlen_t    rs2_value;
    rv_isa_pkg::xlen_t    alu_b;
    rv_isa_pkg::xlen_t    alu_result;
    rv_isa_pkg::xlen_t    load_data;
    rv_isa_pkg::xlen_t    wb_data;
    logic                 equal;

    assign imem_addr = pc;

    fetch_unit #(.reset_pc(reset_pc)) i_fetch_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl      (ctrl),
        .rs1_value (rs1_value),
        .equal     (equal),
        .pc        (pc),
        .pc_plus4  (pc_plus4)
    );

    instr_decoder i_instr_decoder (
        .instr (imem_rdata),
        .ctrl  (ctrl)
    );

    reg_file i_reg_file (
        .clk    (clk),
        .rst_n  (rst_n),
        .wen    (ctrl.reg_wen),
        .waddr  (ctrl.rd),
        .wdata  (wb_data),
        .raddr1 (ctrl.rs1),
        .raddr2 (ctrl.rs2),
        .rdata1 (rs1_value),
        .rdata2 (rs2_value)
    );

    assign alu_b = ctrl.use_imm ? ctrl.imm : rs2_value;

    alu i_alu (
        .a       (rs1_value),
        .b       (alu_b),
        .op      (ctrl.alu_op),
        .word_op (ctrl.word_op),
        .result  (alu_result),
        .equal   (equal)
    );

    // the word at reset_pc is already decoded during reset, keep its strobes off
    always_comb begin
        ctrl_mem           = ctrl;
        ctrl_mem.mem_read  = ctrl.mem_read & rst_n;
        ctrl_mem.mem_write = ctrl.mem_write & rst_n;
    end

    lsu i_lsu (
        .ctrl       (ctrl_mem),
        .addr       (alu_result),  // rs1 + imm
        .store_data (rs2_value),
        .dmem_rdata (dmem_rdata),
        .dmem_req   (dmem_req),
        .load_data  (load_data)
    );

    always_comb begin
        case (ctrl.wb_sel)
            core_ctrl_pkg::wb_load:     wb_data = load_data;
            core_ctrl_pkg::wb_pc_plus4: wb_data = pc_plus4;
            default:                    wb_data = alu_result;
        endcase
    end

endmodule

/* logic/rv_isa_pkg.sv */
package rv_isa_pkg;

    typedef logic [63:0] xlen_t;       // architectural data word
    typedef logic [4:0]  reg_addr_t;   // register index
    typedef logic [31:0] instr_t;      // raw instruction word
    typedef logic [31:0] word_t;       // low half for W results
    typedef logic [7:0]  byte_mask_t;  // one bit per dmem byte lane

    // base R-type layout, other formats reuse the same bit positions
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } instr_fields_t;

    localparam logic [6:0] op_lui       = 7'b0110111;
    localparam logic [6:0] op_op_imm    = 7'b0010011;
    localparam logic [6:0] op_op        = 7'b0110011;
    localparam logic [6:0] op_op_imm_32 = 7'b0011011;
    localparam logic [6:0] op_op_32     = 7'b0111011;
    localparam logic [6:0] op_load      = 7'b0000011;
    localparam logic [6:0] op_store     = 7'b0100011;
    localparam logic [6:0] op_branch    = 7'b1100011;
    localparam logic [6:0] op_jal       = 7'b1101111;
    localparam logic [6:0] op_jalr      = 7'b1100111;

    localparam logic [2:0] f3_add    = 3'b000;  // add, sub, addi, addw, addiw
    localparam logic [2:0] f3_jalr   = 3'b000;
    localparam logic [2:0] f3_byte   = 3'b000;  // lb / sb
    localparam logic [2:0] f3_word   = 3'b010;  // lw / sw
    localparam logic [2:0] f3_double = 3'b011;  // ld / sd
    localparam logic [2:0] f3_beq    = 3'b000;
    localparam logic [2:0] f3_bne    = 3'b001;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_sub  = 7'b0100000;

endpackage

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module tb_rv_core -f filelist.f -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "Done: no errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* testbench/tb_programs.svh */
`ifndef tb_programs_svh
`define tb_programs_svh

typedef struct packed {
    logic [1:0]             kind;
    rv_isa_pkg::xlen_t      addr;   // 8-byte aligned request address
    rv_isa_pkg::byte_mask_t mask;
    rv_isa_pkg::xlen_t      value;  // lane data, or the load address for st_lw / st_ld
} store_t;

localparam logic [1:0] st_lit = 2'd0;
localparam logic [1:0] st_lw  = 2'd1;  // stored register came from an lw
localparam logic [1:0] st_ld  = 2'd2;  // stored register came from an ld

localparam int prog_len   = 40;
localparam int num_stores = 16;

localparam rv_isa_pkg::instr_t program_words [prog_len] = '{
    32'h16003c23,                              // sd x0, already decoded during reset
    32'h123450b7, 32'h67808093, 32'hfff00113,  // x1 = 0x12345678, x2 = -1
    32'h002081b3, 32'h40100233, 32'h10303023,  // add x3, sub x4, sd x3
    32'h10403423, 32'h00500013, 32'h10003823,  // sd x4, addi x0, sd x0
    32'h800002b7, 32'hfff2831b, 32'h006303bb,  // lui x5, addiw x6, addw x7
    32'h10603c23, 32'h12703023, 32'h121005a3,  // sd x6, sd x7, sb lane 3
    32'h12402a23, 32'h12102c23, 32'h00c02483,  // sw upper, sw lower, lw 0x0c
    32'h01003503, 32'h14903023, 32'h14a03423,  // ld 0x10, sd x9, sd x10
    32'h01802583, 32'h14b03823, 32'h00108463,  // lw 0x18, sd x11, beq taken
    32'h1e103c23, 32'h00209463, 32'h1e203c23,  // skipped, bne taken, skipped
    32'h00208463, 32'h14103c23, 32'h00109463,  // beq not taken, sd x1, bne not taken
    32'h16203023, 32'h0080066f, 32'h1e103c23,  // sd x2, jal x12 +8, skipped
    32'h16c03423, 32'h01560767, 32'h1e103c23,  // sd x12, jalr x14 0x15(x12), skipped
    32'h1e203c23, 32'h16e03823, 32'h0000006f   // skipped, sd x14, jal x0 0
};

localparam store_t expected_stores [num_stores] = '{
    '{st_lit, 64'h178, 8'hff, 64'h0},                      // first word after release
    '{st_lit, 64'h100, 8'hff, 64'h0000_0000_1234_5677},
    '{st_lit, 64'h108, 8'hff, 64'hffff_ffff_edcb_a988},
    '{st_lit, 64'h110, 8'hff, 64'h0},                      // x0 stays zero
    '{st_lit, 64'h118, 8'hff, 64'h0000_0000_7fff_ffff},
    '{st_lit, 64'h120, 8'hff, 64'hffff_ffff_ffff_fffe},
    '{st_lit, 64'h128, 8'h08, 64'h0000_0000_7800_0000},
    '{st_lit, 64'h130, 8'hf0, 64'hedcb_a988_0000_0000},
    '{st_lit, 64'h138, 8'h0f, 64'h0000_0000_1234_5678},
    '{st_lw,  64'h140, 8'hff, 64'h00c},
    '{st_ld,  64'h148, 8'hff, 64'h010},
    '{st_lw,  64'h150, 8'hff, 64'h018},
    '{st_lit, 64'h158, 8'hff, 64'h0000_0000_1234_5678},
    '{st_lit, 64'h160, 8'hff, 64'hffff_ffff_ffff_ffff},
    '{st_lit, 64'h168, 8'hff, reset_pc + 64'h84},          // jal link
    '{st_lit, 64'h170, 8'hff, reset_pc + 64'h90}           // jalr link
};

`endif

/* testbench/tb_rv_core.sv */
`timescale 1ns/1ns

module tb_rv_core;

    localparam rv_isa_pkg::xlen_t reset_pc = 64'h0000_0000_8000_0000;
    localparam int mem_words     = 64;
    localparam int store_timeout = 400;

    `include "tb_programs.svh"

    logic                     clk;
    logic                     rst_n;
    rv_isa_pkg::xlen_t        imem_addr;
    rv_isa_pkg::instr_t       imem_rdata;
    core_ctrl_pkg::dmem_req_t dmem_req;
    rv_isa_pkg::xlen_t        dmem_rdata;

    rv_isa_pkg::instr_t imem [mem_words];
    rv_isa_pkg::xlen_t  dmem [mem_words];
    rv_isa_pkg::xlen_t  imem_offset;
    int                 store_idx;

    rv_core #(.reset_pc(reset_pc)) i_rv_core (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata)
    );

    assign imem_offset = imem_addr - reset_pc;
    assign imem_rdata  = (imem_offset < 64'(mem_words * 4)) ? imem[imem_offset[7:2]] : 32'h13;
    assign dmem_rdata  = dmem_req.ren ? dmem[dmem_req.addr[8:3]] : '0;  // combinational read

    always @(posedge clk) begin
        if (rst_n && dmem_req.wen) begin
            for (int b = 0; b < 8; b++) begin
                if (dmem_req.wmask[b]) begin
                    dmem[dmem_req.addr[8:3]][b*8 +: 8] <= dmem_req.wdata[b*8 +: 8];
                end
            end
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic rv_isa_pkg::xlen_t lane_bits(input rv_isa_pkg::byte_mask_t m);
        rv_isa_pkg::xlen_t bits;
        for (int b = 0; b < 8; b++) begin
            bits[b*8 +: 8] = {8{m[b]}};
        end
        return bits;
    endfunction

    // load results follow from the preset memory and the sign-extension rule
    function automatic rv_isa_pkg::xlen_t expected_value(input store_t s);
        rv_isa_pkg::xlen_t src;
        logic [31:0]       w;
        rv_isa_pkg::xlen_t res;
        src = dmem[s.value[8:3]];
        w   = s.value[2] ? src[63:32] : src[31:0];
        case (s.kind)
            st_lw:   res = {{32{w[31]}}, w};
            st_ld:   res = src;
            default: res = s.value;
        endcase
        return res;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic fill_memories();
        logic [31:0] r;
        r = 32'h30e18884;
        for (int i = 0; i < mem_words; i++) begin
            r = xorshift(r);
            dmem[i][63:32] = r;
            r = xorshift(r);
            dmem[i][31:0] = r ^ 32'(i);
            imem[i] = 32'h13;  // nop outside the program
        end
        dmem[1][63] = 1'b1;  // word at 0x0c negative
        dmem[3][31] = 1'b0;  // word at 0x18 positive
        for (int i = 0; i < prog_len; i++) begin
            imem[i] = program_words[i];
        end
    endtask

    task automatic check_store(input store_t s);
        rv_isa_pkg::xlen_t lanes;
        rv_isa_pkg::xlen_t exp_data;
        lanes    = lane_bits(s.mask);
        exp_data = expected_value(s) & lanes;
        assert (dmem_req.addr == s.addr && dmem_req.wmask == s.mask)
            else fail_run($sformatf("Error at %0t ns: store %0d at %h mask %h, expected %h mask %h",
                                    $time, store_idx, dmem_req.addr, dmem_req.wmask, s.addr, s.mask));
        assert ((dmem_req.wdata & lanes) == exp_data)
            else fail_run($sformatf("Error at %0t ns: store %0d data %h, expected %h",
                                    $time, store_idx, dmem_req.wdata & lanes, exp_data));
    endtask

    // stable point between edges
    always @(negedge clk) begin
        if (!rst_n) begin
            assert (!dmem_req.wen && !dmem_req.ren && imem_addr == reset_pc)
                else fail_run($sformatf("Error at %0t ns: strobe or pc %h wrong during reset",
                                        $time, imem_addr));
        end else begin
            assert (imem_addr[1:0] == 2'b00)
                else fail_run($sformatf("Error at %0t ns: fetch from unaligned pc %h",
                                        $time, imem_addr));
            if (dmem_req.wen) begin
                assert (store_idx < num_stores)
                    else fail_run($sformatf("Error at %0t ns: unexpected store to %h",
                                            $time, dmem_req.addr));
                check_store(expected_stores[store_idx]);
                store_idx++;
            end
        end
    end

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        int cycles;
        rst_n     = 1'b0;
        store_idx = 0;
        fill_memories();
        repeat (5) @(posedge clk);
        #10 rst_n = 1'b1;
        @(negedge clk);
        assert (imem_addr == reset_pc)
            else fail_run($sformatf("Error at %0t ns: first fetch at %h", $time, imem_addr));
        cycles = 0;
        while (store_idx < num_stores && cycles < store_timeout) begin
            @(posedge clk);
            cycles++;
        end
        if (store_idx < num_stores) begin
            fail_run($sformatf("timeout: only %0d of %0d expected stores were seen",
                               store_idx, num_stores));
        end else begin
            repeat (20) @(posedge clk);  // a late write trips the checker
            $display("Done: no errors");
            $finish;
        end
    end

endmodule
